// File: logic/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

////////////////////
// datapath widths
////////////////////

`define MIPS_WORD_W 32      // data word
`define MIPS_PC_W 8         // byte address of the program counter

////////////////////
// storage depths
////////////////////

`define MIPS_IMEM_WORDS 64  // instruction words
`define MIPS_DMEM_WORDS 64  // data words
`define MIPS_REG_COUNT 32   // general registers

`endif

// File: logic/mips_pkg.sv
package mips_pkg;

    `include "mips_macros.svh"

    typedef logic [`MIPS_WORD_W-1:0] word_t;
    typedef logic [`MIPS_PC_W-1:0] pc_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_NOR = 6'b100111,
        FN_SLT = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOR, ALU_SLT, ALU_LUI
    } alu_op_e;

    typedef enum logic {
        FETCH_IDLE, FETCH_BUSY
    } fetch_state_e;

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module fetch_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
    input  mips_pkg::word_t                     imem_wdata,
    input  logic                                redirect_en,
    input  mips_pkg::pc_t                       redirect_pc,
    input  logic                                retire,
    output logic                                dec_valid,
    output mips_pkg::word_t                     instr,
    output mips_pkg::pc_t                       pc,
    output mips_pkg::pc_t                       pc_plus4
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(`MIPS_IMEM_WORDS);
    localparam pc_t PC_STEP = pc_t'(4);

    word_t        imem [`MIPS_IMEM_WORDS];
    pc_t          pc_q;     // next fetch address
    fetch_state_e state;
    logic         issue;

    assign issue = run && (state == FETCH_IDLE);

    ////////////////////
    // issue control
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= FETCH_IDLE;
            pc_q      <= '0;
            pc        <= '0;
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= issue;
            case (state)
                FETCH_IDLE: if (issue) state <= FETCH_BUSY;
                FETCH_BUSY: if (retire) state <= FETCH_IDLE;
                default:    state <= FETCH_IDLE;
            endcase
            if (issue)
                pc <= pc_q;
            if (redirect_en)
                pc_q <= redirect_pc;    // taken branch or jump
            else if (issue)
                pc_q <= pc_q + PC_STEP;
        end
    end

    ////////////////////
    // instruction memory
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (imem_we)
            imem[imem_addr] <= imem_wdata;  // load port
        if (issue)
        begin
            instr    <= imem[pc_q[IDX_W+1:2]];
            pc_plus4 <= pc_q + PC_STEP;
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                dec_valid,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::pc_t       pc,
    input  mips_pkg::pc_t       pc_plus4,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output logic                ex_valid,
    output mips_pkg::alu_op_e   alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_jump,
    output logic                ovf_check,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    output mips_pkg::word_t     imm_ext,
    output mips_pkg::reg_addr_t dest_reg,
    output mips_pkg::pc_t       pc_out,
    output mips_pkg::pc_t       pc_plus4_out,
    output mips_pkg::pc_t       jump_pc
);
    import mips_pkg::*;

    word_t     regs [`MIPS_REG_COUNT];
    opcode_e   op;
    funct_e    fn;
    reg_addr_t rs, rt, rd, dest_d;
    imm_t      imm;
    alu_op_e   alu_d;
    logic      use_imm_d, reg_write_d, mem_read_d, mem_write_d;
    logic      beq_d, bne_d, jump_d, ovf_d, zero_ext;

    assign op  = opcode_e'(instr[31:26]);
    assign fn  = funct_e'(instr[5:0]);
    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[15:0];

    always_comb
    begin
        alu_d = ALU_ADD;
        {use_imm_d, reg_write_d, mem_read_d, mem_write_d} = 4'b0000;
        {beq_d, bne_d, jump_d, ovf_d, zero_ext} = 5'b00000;
        dest_d = rt;
        case (op)
            OP_RTYPE:
            begin
                dest_d      = rd;
                reg_write_d = 1'b1;
                case (fn)
                    FN_ADD: begin alu_d = ALU_ADD; ovf_d = 1'b1; end
                    FN_SUB: begin alu_d = ALU_SUB; ovf_d = 1'b1; end
                    FN_AND: alu_d = ALU_AND;
                    FN_OR:  alu_d = ALU_OR;
                    FN_NOR: alu_d = ALU_NOR;
                    FN_SLT: alu_d = ALU_SLT;
                    default: reg_write_d = 1'b0;    // unknown funct is a no-op
                endcase
            end
            OP_ADDI: {use_imm_d, reg_write_d, ovf_d} = 3'b111;
            OP_SLTI: begin alu_d = ALU_SLT; {use_imm_d, reg_write_d} = 2'b11; end
            OP_ANDI: begin alu_d = ALU_AND; {use_imm_d, reg_write_d, zero_ext} = 3'b111; end
            OP_ORI:  begin alu_d = ALU_OR; {use_imm_d, reg_write_d, zero_ext} = 3'b111; end
            OP_LUI:  begin alu_d = ALU_LUI; {use_imm_d, reg_write_d} = 2'b11; end
            OP_LW:   {use_imm_d, reg_write_d, mem_read_d} = 3'b111;
            OP_SW:   {use_imm_d, mem_write_d} = 2'b11;
            OP_BEQ:  begin alu_d = ALU_SUB; beq_d = 1'b1; end
            OP_BNE:  begin alu_d = ALU_SUB; bne_d = 1'b1; end
            OP_J:    jump_d = 1'b1;
            default: ;  // unknown opcode retires with no effect
        endcase
    end

    ////////////////////
    // register file
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_reg != '0)
            regs[wb_reg] <= wb_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_valid <= 1'b0;
            alu_op   <= ALU_ADD;
            {use_imm, reg_write, mem_read, mem_write} <= 4'b0000;
            {is_beq, is_bne, is_jump, ovf_check} <= 4'b0000;
        end
        else
        begin
            ex_valid <= dec_valid;
            if (dec_valid)
            begin
                alu_op <= alu_d;
                {use_imm, reg_write, mem_read, mem_write} <=
                    {use_imm_d, reg_write_d, mem_read_d, mem_write_d};
                {is_beq, is_bne, is_jump, ovf_check} <= {beq_d, bne_d, jump_d, ovf_d};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_valid)
        begin
            rs_val       <= regs[rs];
            rt_val       <= regs[rt];
            imm_ext      <= zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
            dest_reg     <= dest_d;
            pc_out       <= pc;
            pc_plus4_out <= pc_plus4;
            jump_pc      <= {instr[5:0], 2'b00};  // target field in words
        end
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  mips_pkg::alu_op_e   alu_op,
    input  logic                use_imm,
    input  logic                reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                is_beq,
    input  logic                is_bne,
    input  logic                is_jump,
    input  logic                ovf_check,
    input  mips_pkg::word_t     rs_val,
    input  mips_pkg::word_t     rt_val,
    input  mips_pkg::word_t     imm_ext,
    input  mips_pkg::reg_addr_t dest_reg,
    input  mips_pkg::pc_t       pc,
    input  mips_pkg::pc_t       pc_plus4,
    input  mips_pkg::pc_t       jump_pc,
    output logic                mem_valid,
    output mips_pkg::word_t     result,
    output mips_pkg::word_t     store_data,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_reg_write,
    output logic                mem_read_q,
    output logic                mem_write_q,
    output logic                overflow_q,
    output mips_pkg::pc_t       mem_pc,
    output logic                redirect_en,
    output mips_pkg::pc_t       redirect_pc
);
    import mips_pkg::*;

    word_t op_b, addend, sum, alu_res;
    logic  is_sub, ovf_raw, taken;
    pc_t   branch_pc;

    assign op_b    = use_imm ? imm_ext : rt_val;
    assign is_sub  = (alu_op == ALU_SUB);
    assign addend  = is_sub ? ~op_b : op_b;
    assign sum     = rs_val + addend + word_t'(is_sub);  // also lw/sw address
    assign ovf_raw = (rs_val[31] == addend[31]) && (sum[31] != rs_val[31]);

    always_comb
    begin
        case (alu_op)
            ALU_AND: alu_res = rs_val & op_b;
            ALU_OR:  alu_res = rs_val | op_b;
            ALU_NOR: alu_res = ~(rs_val | op_b);
            ALU_SLT: alu_res = word_t'($signed(rs_val) < $signed(op_b));
            ALU_LUI: alu_res = {op_b[15:0], 16'b0};
            default: alu_res = sum;     // add and sub
        endcase
    end

    assign taken     = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign branch_pc = pc_plus4 + {imm_ext[5:0], 2'b00};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_valid   <= 1'b0;
            redirect_en <= 1'b0;
            {mem_reg_write, mem_read_q, mem_write_q, overflow_q} <= 4'b0000;
        end
        else
        begin
            mem_valid   <= ex_valid;
            redirect_en <= ex_valid && (taken || is_jump);  // pulse with mem_valid
            if (ex_valid)
                {mem_reg_write, mem_read_q, mem_write_q, overflow_q} <=
                    {reg_write, mem_read, mem_write, ovf_check && ovf_raw};
        end
    end

    always_ff @(posedge clk)
    begin
        if (ex_valid)
        begin
            result      <= alu_res;
            store_data  <= rt_val;
            mem_dest    <= dest_reg;
            mem_pc      <= pc;
            redirect_pc <= is_jump ? jump_pc : branch_pc;
        end
    end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_valid,
    input  mips_pkg::word_t     result,
    input  mips_pkg::word_t     store_data,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_read_q,
    input  logic                mem_write_q,
    input  logic                overflow_q,
    input  mips_pkg::pc_t       mem_pc,
    output logic                retire,
    output mips_pkg::pc_t       retire_pc,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data,
    output logic                overflow,
    output logic                store_en,
    output mips_pkg::word_t     store_addr,
    output mips_pkg::word_t     store_data_out
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

    word_t             dmem [`MIPS_DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = result[IDX_W+1:2];    // word index from byte address

    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_write_q)
            dmem[idx] <= store_data;
        if (mem_valid)
        begin
            wb_reg         <= mem_dest;
            wb_data        <= mem_read_q ? dmem[idx] : result;
            retire_pc      <= mem_pc;
            store_addr     <= result;
            store_data_out <= store_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            {retire, wb_en, overflow, store_en} <= 4'b0000;
        end
        else
        begin
            retire   <= mem_valid;
            wb_en    <= mem_valid && mem_reg_write && (mem_dest != '0);  // r0 stays zero
            overflow <= mem_valid && overflow_q;
            store_en <= mem_valid && mem_write_q;
        end
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module mips_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                imem_we,
    input  logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_addr,
    input  mips_pkg::word_t                     imem_wdata,
    output logic                                retire,
    output mips_pkg::pc_t                       retire_pc,
    output logic                                wb_en,
    output mips_pkg::reg_addr_t                 wb_reg,
    output mips_pkg::word_t                     wb_data,
    output logic                                overflow,
    output logic                                store_en,
    output mips_pkg::word_t                     store_addr,
    output mips_pkg::word_t                     store_data
);
    import mips_pkg::*;

    // fetch to decode
    logic      dec_valid;
    word_t     instr;
    pc_t       dec_pc, dec_pc_plus4;
    // decode to execute
    logic      ex_valid, use_imm, reg_write, mem_read, mem_write;
    logic      is_beq, is_bne, is_jump, ovf_check;
    alu_op_e   alu_op;
    word_t     rs_val, rt_val, imm_ext;
    reg_addr_t dest_reg;
    pc_t       ex_pc, ex_pc_plus4, jump_pc;
    // execute to memory and fetch
    logic      mem_valid, mem_reg_write, mem_read_q, mem_write_q, overflow_q;
    word_t     result, ex_store_data;
    reg_addr_t mem_dest;
    pc_t       mem_pc, redirect_pc;
    logic      redirect_en;

    fetch_stage fetch_i (
        .clk, .reset, .run, .imem_we, .imem_addr, .imem_wdata,
        .redirect_en, .redirect_pc, .retire,
        .dec_valid, .instr, .pc(dec_pc), .pc_plus4(dec_pc_plus4)
    );

    decode_stage decode_i (
        .clk, .reset, .dec_valid, .instr, .pc(dec_pc), .pc_plus4(dec_pc_plus4),
        .wb_en, .wb_reg, .wb_data,
        .ex_valid, .alu_op, .use_imm, .reg_write, .mem_read, .mem_write,
        .is_beq, .is_bne, .is_jump, .ovf_check, .rs_val, .rt_val, .imm_ext,
        .dest_reg, .pc_out(ex_pc), .pc_plus4_out(ex_pc_plus4), .jump_pc
    );

    execute_stage execute_i (
        .clk, .reset, .ex_valid, .alu_op, .use_imm, .reg_write, .mem_read, .mem_write,
        .is_beq, .is_bne, .is_jump, .ovf_check, .rs_val, .rt_val, .imm_ext,
        .dest_reg, .pc(ex_pc), .pc_plus4(ex_pc_plus4), .jump_pc,
        .mem_valid, .result, .store_data(ex_store_data), .mem_dest, .mem_reg_write,
        .mem_read_q, .mem_write_q, .overflow_q, .mem_pc, .redirect_en, .redirect_pc
    );

    memory_stage memory_i (
        .clk, .reset, .mem_valid, .result, .store_data(ex_store_data), .mem_dest,
        .mem_reg_write, .mem_read_q, .mem_write_q, .overflow_q, .mem_pc,
        .retire, .retire_pc, .wb_en, .wb_reg, .wb_data, .overflow,
        .store_en, .store_addr, .store_data_out(store_data)
    );

endmodule

// File: verification/mips_props.sv
`timescale 1ns/1ns

module mips_props (
    input logic clk,
    input logic reset,
    input logic run,
    input logic retire,
    input logic wb_en,
    input logic store_en,
    input logic overflow
);
    int assert_failures = 0;

    reset_quiet: assert property (@(posedge clk)
        reset |=> !(retire || wb_en || store_en || overflow))
        else begin assert_failures++; $error("retire or a report active after reset"); end

    ////////////////////
    // retire cadence
    ////////////////////

    retire_spacing: assert property (@(posedge clk) disable iff (reset)
        retire |-> !($past(retire, 1) || $past(retire, 2) || $past(retire, 3) || $past(retire, 4)))
        else begin assert_failures++; $error("retire pulses closer than 5 cycles"); end

    retire_cadence: assert property (@(posedge clk) disable iff (reset)
        ($past(retire, 5) && $past(run, 4)) |-> retire)
        else begin assert_failures++; $error("retire missing 5 cycles after the last one"); end

    // one in-flight instruction may still drain
    drain_after_stop: assert property (@(posedge clk) disable iff (reset)
        (!run && !$past(run, 1) && !$past(run, 2) && !$past(run, 3) && !$past(run, 4)) |-> !retire)
        else begin assert_failures++; $error("retire long after run went low"); end

endmodule

bind mips_core mips_props props_i (
    .clk(clk), .reset(reset), .run(run), .retire(retire), .wb_en(wb_en),
    .store_en(store_en), .overflow(overflow)
);

// File: verification/mips_tb.sv
`timescale 1ns/1ns
`include "mips_macros.svh"

module mips_tb;
    import mips_pkg::*;

    localparam bit [31:0] SEED = 32'hb2f2dfce;
    localparam int WAIT_LIMIT = 20;         // cycles per retire wait

    logic       clk = 1'b0;
    logic       reset, run, imem_we;
    logic [5:0] imem_addr;
    word_t      imem_wdata;
    logic       retire, wb_en, overflow, store_en;
    pc_t        retire_pc;
    reg_addr_t  wb_reg;
    word_t      wb_data, store_addr, store_data;

    word_t      prog [`MIPS_IMEM_WORDS];
    word_t      m_regs [`MIPS_REG_COUNT];   // reference register file
    word_t      m_dmem [`MIPS_DMEM_WORDS];
    int         prog_len, value_errors, timeouts;
    pc_t        m_pc, cur_pc;
    logic       e_wb_en, e_ovf, e_st_en;
    reg_addr_t  e_wb_reg;
    word_t      e_wb_data, e_st_addr, e_st_data;

    always #10 clk = ~clk;

    mips_core dut_i (.*);

    function automatic word_t rtype_word(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {6'b000000, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic word_t itype_word(opcode_e op, reg_addr_t rt, reg_addr_t rs, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(int target);
        return {OP_J, 26'(target)};     // target in words
    endfunction

    function automatic reg_addr_t pick_src();
        return reg_addr_t'(1 + $urandom_range(5));
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (exp === act)
        else
        begin
            $display("ERROR %s pc %h expected %h actual %h", name, cur_pc, exp, act);
            value_errors++;
        end
    endtask

    task automatic wait_retire(output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            ok = retire;
            n++;
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    task automatic model_step(input word_t ins);
        word_t a, b, sx, zx, res, addr;
        pc_t   next;
        a    = m_regs[ins[25:21]];
        b    = m_regs[ins[20:16]];
        sx   = {{16{ins[15]}}, ins[15:0]};
        zx   = {16'b0, ins[15:0]};
        addr = a + sx;
        res  = '0;
        next = m_pc + 8'd4;
        {e_wb_en, e_ovf, e_st_en} = 3'b000;
        e_wb_reg  = ins[20:16];
        e_st_addr = addr;
        e_st_data = b;
        case (opcode_e'(ins[31:26]))
            OP_RTYPE:
            begin
                e_wb_reg = ins[15:11];
                e_wb_en  = 1'b1;
                case (funct_e'(ins[5:0]))
                    FN_ADD:
                    begin
                        res   = a + b;
                        e_ovf = (a[31] == b[31]) && (res[31] != a[31]);
                    end
                    FN_SUB:
                    begin
                        res   = a - b;
                        e_ovf = (a[31] != b[31]) && (res[31] != a[31]);
                    end
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: e_wb_en = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                res     = a + sx;
                e_ovf   = (a[31] == sx[31]) && (res[31] != a[31]);
                e_wb_en = 1'b1;
            end
            OP_SLTI: {e_wb_en, res} = {1'b1, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0};
            OP_ANDI: {e_wb_en, res} = {1'b1, a & zx};    // zero-extended
            OP_ORI:  {e_wb_en, res} = {1'b1, a | zx};
            OP_LUI:  {e_wb_en, res} = {1'b1, ins[15:0], 16'b0};
            OP_LW:   {e_wb_en, res} = {1'b1, m_dmem[addr[7:2]]};
            OP_SW:
            begin
                e_st_en = 1'b1;
                m_dmem[addr[7:2]] = b;
            end
            OP_BEQ:  if (a == b) next = pc_t'(32'(m_pc) + 32'd4 + (sx << 2));
            OP_BNE:  if (a != b) next = pc_t'(32'(m_pc) + 32'd4 + (sx << 2));
            OP_J:    next = pc_t'({ins[25:0], 2'b00});
            default: ;
        endcase
        e_wb_data = res;
        if (e_wb_reg == '0)
            e_wb_en = 1'b0;
        if (e_wb_en)
            m_regs[e_wb_reg] = res;
        m_pc = next;
    endtask

    task automatic compare_retire();
        cur_pc = m_pc;
        check_word("retire_pc", word_t'(m_pc), word_t'(retire_pc));
        model_step(prog[m_pc[7:2]]);
        check_word("wb_en", word_t'(e_wb_en), word_t'(wb_en));
        if (e_wb_en)
        begin
            check_word("wb_reg", word_t'(e_wb_reg), word_t'(wb_reg));
            check_word("wb_data", e_wb_data, wb_data);
        end
        check_word("overflow", word_t'(e_ovf), word_t'(overflow));
        check_word("store_en", word_t'(e_st_en), word_t'(store_en));
        if (e_st_en)
        begin
            check_word("store_addr", e_st_addr, store_addr);
            check_word("store_data", e_st_data, store_data);
        end
    endtask

    ////////////////////
    // program
    ////////////////////

    task automatic build_program();
        imm_t off;
        off = imm_t'($urandom_range(62) * 4);
        emit(rtype_word(FN_ADD, 5'd1, 5'd2, 5'd3));             // unwritten sources
        emit(itype_word(OP_ADDI, 5'd0, 5'd0, imm_t'($urandom)));
        for (int r = 1; r <= 6; r++)
        begin
            emit(itype_word(OP_LUI, reg_addr_t'(r), 5'd0, imm_t'($urandom)));
            emit(itype_word(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), imm_t'($urandom)));
        end
        emit(rtype_word(FN_ADD, 5'd7, pick_src(), pick_src()));
        emit(rtype_word(FN_SUB, 5'd8, pick_src(), pick_src()));
        emit(rtype_word(FN_AND, 5'd9, pick_src(), pick_src()));
        emit(rtype_word(FN_OR, 5'd10, pick_src(), pick_src()));
        emit(rtype_word(FN_NOR, 5'd11, pick_src(), pick_src()));
        emit(rtype_word(FN_SLT, 5'd12, pick_src(), pick_src()));
        emit(itype_word(OP_ADDI, 5'd13, pick_src(), imm_t'($urandom)));
        emit(itype_word(OP_SLTI, 5'd14, pick_src(), imm_t'($urandom)));
        emit(itype_word(OP_ANDI, 5'd15, pick_src(), imm_t'($urandom) | 16'h8000)); // top bit set
        emit(itype_word(OP_ORI, 5'd16, pick_src(), imm_t'($urandom) | 16'h8000));
        emit(itype_word(OP_LUI, 5'd17, pick_src(), imm_t'($urandom)));
        // edge operands for the overflow flag
        emit(itype_word(OP_LUI, 5'd18, 5'd0, 16'h7fff));
        emit(itype_word(OP_ORI, 5'd18, 5'd18, 16'hffff));
        emit(itype_word(OP_ADDI, 5'd19, 5'd18, 16'h0001));
        emit(itype_word(OP_LUI, 5'd20, 5'd0, 16'h8000));
        emit(rtype_word(FN_SLT, 5'd12, 5'd20, 5'd18));          // signed order only
        emit(itype_word(OP_SLTI, 5'd14, 5'd18, 16'hffff));
        emit(rtype_word(FN_SUB, 5'd21, 5'd20, 5'd18));
        emit(rtype_word(FN_ADD, 5'd22, 5'd18, 5'd18));
        emit(itype_word(OP_ADDI, 5'd23, 5'd20, 16'hffff));
        emit(rtype_word(FN_SUB, 5'd24, 5'd18, 5'd20));
        emit(rtype_word(FN_ADD, 5'd25, pick_src(), pick_src()));
        emit(rtype_word(FN_SUB, 5'd26, pick_src(), pick_src()));
        emit(itype_word(OP_SW, 5'd7, 5'd0, off));
        emit(itype_word(OP_SW, 5'd8, 5'd0, off + 16'd4));
        emit(itype_word(OP_LW, 5'd27, 5'd0, off));
        emit(itype_word(OP_LW, 5'd28, 5'd0, off + 16'd4));
        emit(itype_word(OP_BEQ, 5'd1, 5'd1, 16'd1));            // taken
        emit(itype_word(OP_ADDI, 5'd29, 5'd0, 16'h0bad));
        emit(itype_word(OP_BNE, 5'd1, 5'd1, 16'd1));            // not taken
        emit(itype_word(OP_ADDI, 5'd29, 5'd0, 16'h0001));
        emit(itype_word(OP_BNE, 5'd9, 5'd10, 16'd1));
        emit(itype_word(OP_ORI, 5'd30, 5'd0, 16'h0002));
        emit(itype_word(OP_BEQ, 5'd2, 5'd3, 16'd1));
        emit(itype_word(OP_ORI, 5'd30, 5'd30, 16'h0004));
        emit(jump_word(prog_len + 2));
        emit(itype_word(OP_ADDI, 5'd31, 5'd0, 16'h0bad));
        emit(rtype_word(FN_OR, 5'd31, 5'd27, 5'd28));
    endtask

    initial
    begin
        bit  ok;
        int  retired;
        pc_t end_pc;
        void'($urandom(SEED));
        {value_errors, timeouts, prog_len, retired} = '0;
        reset      <= 1'b1;
        run        <= 1'b0;
        imem_we    <= 1'b0;
        imem_addr  <= '0;
        imem_wdata <= '0;
        cur_pc = '0;
        for (int i = 0; i < `MIPS_REG_COUNT; i++)
            m_regs[i] = '0;
        build_program();
        end_pc = pc_t'(prog_len * 4);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_word("reset state", '0, word_t'({retire, wb_en, store_en, overflow}));

        for (int i = 0; i < prog_len; i++)
        begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= 6'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;

        m_pc = '0;
        ok = 1'b1;
        while (ok && m_pc != end_pc && retired < 200)
        begin
            wait_retire(ok);
            if (ok)
            begin
                compare_retire();
                retired++;
            end
            else
            begin
                $display("timeout: no retire seen for pc %h", m_pc);
                timeouts++;
            end
        end
        if (ok && m_pc != end_pc)
        begin
            $display("program never reached its last instruction");
            timeouts++;
        end
        @(posedge clk);
        run <= 1'b0;
        repeat (8) @(negedge clk);     // room for a stray retire

        $display("%0d retired, %0d value errors, %0d timeouts, %0d property failures",
                 retired, value_errors, timeouts, dut_i.props_i.assert_failures);
        if (value_errors + timeouts + dut_i.props_i.assert_failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
verification/mips_props.sv
verification/mips_tb.sv

// File: Makefile
TOP             ?= mips_tb
FILELIST        ?= compile.f
OBJ_DIR         ?= obj_dir
SEED_LOG        ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert -j 0

.PHONY: all build compile run clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

compile: build

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(SEED_LOG)
	@grep -q -F "** PASS **" $(SEED_LOG) || (echo "simulation failed, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)
